// File: rtl/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// memory port is word addressed, 512 words
`define MEM_ADDR_BITS 9

`define MULDIV_CYCLES 8 // aluStart to aluDone for mul and div

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

// File: rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// reference numbering, 11 is a hole and runs as nop
	typedef enum logic [4:0] {
		opLd = 5'd0, opLdi = 5'd1, opSt = 5'd2,
		opAdd = 5'd3, opSub = 5'd4, opShr = 5'd5, opShl = 5'd6,
		opRor = 5'd7, opRol = 5'd8, opAnd = 5'd9, opOr = 5'd10,
		opAddi = 5'd12, opAndi = 5'd13, opOri = 5'd14,
		opMul = 5'd15, opDiv = 5'd16, opNeg = 5'd17, opNot = 5'd18,
		opBr = 5'd19, opJr = 5'd20, opJal = 5'd21,
		opIn = 5'd22, opOut = 5'd23, opMfhi = 5'd24, opMflo = 5'd25,
		opNop = 5'd26, opHalt = 5'd27
	} opcodeT;

	// branch condition sits in the low bits of rb
	typedef enum logic [1:0] {
		condZero, condNonzero, condPositive, condNegative
	} branchCondT;

	typedef struct packed {
		opcodeT opcode;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [14:0] spare; // ignored
	} regFormT;

	typedef struct packed {
		opcodeT opcode;
		logic [3:0] ra;
		logic [3:0] rb;
		logic signed [18:0] constant; // sign extended onto the bus
	} immFormT;

	typedef union packed {
		regFormT regForm;
		immFormT immForm;
	} instructionT;

endpackage

`default_nettype wire

// File: rtl/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
	input logic clock,
	input logic reset,
	input cpuPkg::instructionT ir,
	input logic branchTaken,
	input logic aluDone,
	output cpuPkg::opcodeT aluOp,
	output logic aluStart,
	output logic read, write,
	output logic PCout, MDRout, Immout, InPortout, RZLOout, // bus sources
	output logic RZHIout, RHIout, RLOout, Rout,
	output logic PCin, IRin, MARin, MDRin, RYin, RZin, // register loads
	output logic RHIin, RLOin, OutPortin, conIn, incPC,
	output logic Gra, Grb, Grc, Rin, BAout, linkIn, // register file
	output logic halted,
	output logic [15:0] instrCount
);
	import cpuPkg::*;

	// listed in flow order, a plain step goes to the next entry
	typedef enum logic [5:0] {
		stReset, stFetch0, stFetch1, stFetch2, stDecode,
		stAddr0, stAddr1, stAddrMar, stLdRead, stLdWrite, stStData, stStWrite,
		stAlu0, stAluReg, stAluImm, stResult, stUnary,
		stMd0, stMd1, stMdWait, stMdHi, stMdLo,
		stBr0, stBr1, stBr2, stBr3,
		stJr, stJal0, stJal1, stIn, stOut, stMfhi, stMflo,
		stNop0, stNop1, stNop2, stNop3, stNop4,
		stHalt
	} stateT;

	stateT state, nextState;
	opcodeT opcode;

	assign opcode = ir.regForm.opcode;
	assign halted = (state == stHalt);

	// ALU steps of an operation take the opcode, address and branch sums use add
	assign aluOp = (state inside {stAluReg, stAluImm, stUnary, stMd1, stMdWait}) ? opcode : opAdd;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= stReset;
			instrCount <= '0;
		end else begin
			state <= nextState;
			if (state == stFetch2)
				instrCount <= instrCount + 16'd1; // one per fetched instruction
		end
	end

	always_comb begin
		nextState = stateT'(state + 6'd1);
		case (state)
			stDecode: begin
				case (opcode)
					opLd, opLdi, opSt: nextState = stAddr0;
					opAdd, opSub, opShr, opShl, opRor, opRol, opAnd, opOr,
					opAddi, opAndi, opOri: nextState = stAlu0;
					opMul, opDiv: nextState = stMd0;
					opNeg, opNot: nextState = stUnary;
					opBr: nextState = stBr0;
					opJr: nextState = stJr;
					opJal: nextState = stJal0;
					opIn: nextState = stIn;
					opOut: nextState = stOut;
					opMfhi: nextState = stMfhi;
					opMflo: nextState = stMflo;
					opHalt: nextState = stHalt;
					default: nextState = stNop0; // nop and the unused code
				endcase
			end
			stAddr1: nextState = (opcode == opLdi) ? stResult : stAddrMar;
			stAddrMar: nextState = (opcode == opLd) ? stLdRead : stStData;
			stAlu0: nextState = (opcode inside {opAddi, opAndi, opOri}) ? stAluImm : stAluReg;
			stAluReg, stUnary: nextState = stResult;
			stMdWait: nextState = aluDone ? stMdHi : stMdWait; // mul/div still running
			stJr, stIn, stOut, stMfhi, stMflo: nextState = stNop1; // pad to nop length
			stJal1: nextState = stNop2;
			stLdWrite, stStWrite, stResult, stMdLo, stBr3, stNop4: nextState = stFetch0;
			stHalt: nextState = stHalt;
			default: ;
		endcase
	end

	// each strobe is high for exactly one state
	always_comb begin
		{read, write, aluStart, incPC} = '0;
		{PCout, MDRout, Immout, InPortout, RZLOout, RZHIout, RHIout, RLOout, Rout} = '0;
		{PCin, IRin, MARin, MDRin, RYin, RZin, RHIin, RLOin, OutPortin, conIn} = '0;
		{Gra, Grb, Grc, Rin, BAout, linkIn} = '0;
		case (state)
			stFetch0: {PCout, MARin, incPC} = '1;
			stFetch1: {read, MDRin} = '1;
			stFetch2: {MDRout, IRin} = '1;
			stAddr0: {Grb, Rout, BAout, RYin} = '1; // base, r0 gives zero
			stAddr1: {Immout, RZin, aluStart} = '1; // base plus offset
			stAddrMar: {RZLOout, MARin} = '1;
			stLdRead: {read, MDRin} = '1;
			stLdWrite: {MDRout, Gra, Rin} = '1;
			stStData: {Gra, Rout, MDRin} = '1; // store data through the MDR
			stStWrite: write = 1'b1;
			stAlu0: {Grb, Rout, RYin} = '1;
			stAluReg: {Grc, Rout, RZin, aluStart} = '1;
			stAluImm: {Immout, RZin, aluStart} = '1;
			stResult: {RZLOout, Gra, Rin} = '1;
			stUnary: {Grb, Rout, RZin, aluStart} = '1; // neg and not skip RY
			stMd0: {Gra, Rout, RYin} = '1;
			stMd1: {Grb, Rout, aluStart} = '1;
			stMdWait: RZin = aluDone;
			stMdHi: {RZHIout, RHIin} = '1;
			stMdLo: {RZLOout, RLOin} = '1;
			stBr0: {Gra, Rout, conIn} = '1; // test ra
			stBr1: {PCout, RYin} = '1;
			stBr2: {Immout, RZin, aluStart} = '1; // target is pc plus offset
			stBr3: {RZLOout, PCin} = {2{branchTaken}};
			stJr: {Gra, Rout, PCin} = '1;
			stJal0: {PCout, linkIn} = '1; // return address to r15
			stJal1: {Gra, Rout, PCin} = '1;
			stIn: {InPortout, Gra, Rin} = '1;
			stOut: {Gra, Rout, OutPortin} = '1;
			stMfhi: {RHIout, Gra, Rin} = '1;
			stMflo: {RLOout, Gra, Rin} = '1;
			default: ; // reset, decode, nop and halt drive nothing
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/dataPath.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module dataPath (
	input logic clock,
	input logic reset,
	input logic PCout, MDRout, Immout, InPortout, RZLOout,
	input logic RZHIout, RHIout, RLOout, Rout,
	input logic PCin, IRin, MARin, MDRin, RYin, RZin,
	input logic RHIin, RLOin, OutPortin, conIn, incPC,
	input logic [31:0] rfData,
	input logic [31:0] aluLo, aluHi,
	output logic [31:0] busOut,
	output logic [31:0] ryOut,
	output cpuPkg::instructionT ir,
	output logic branchTaken,
	output logic [`MEM_ADDR_BITS-1:0] memAddress, // this is the MAR
	output logic [31:0] memWriteData,
	input logic [31:0] memReadData,
	input logic read,
	input logic [31:0] inPort,
	output logic [31:0] outPort,
	output logic outStrobe
);
	import cpuPkg::*;

	logic [31:0] pc, mdr, rzLo, rzHi, hi, lo;
	logic [31:0] immExt;
	logic condMet;

	assign immExt = {{13{ir.immForm.constant[18]}}, ir.immForm.constant};
	assign memWriteData = mdr;

	// one source at a time, idle bus reads zero
	always_comb begin
		busOut = '0;
		if (PCout) busOut = pc;
		if (MDRout) busOut = mdr;
		if (Immout) busOut = immExt;
		if (InPortout) busOut = inPort;
		if (RZLOout) busOut = rzLo;
		if (RZHIout) busOut = rzHi;
		if (RHIout) busOut = hi;
		if (RLOout) busOut = lo;
		if (Rout) busOut = rfData;
	end

	always_comb begin
		condMet = 1'b0;
		case (branchCondT'(ir.immForm.rb[1:0]))
			condZero: condMet = (busOut == '0);
			condNonzero: condMet = (busOut != '0);
			condPositive: condMet = !busOut[31] && (busOut != '0); // strictly above zero
			condNegative: condMet = busOut[31];
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= `RESET_PC;
			branchTaken <= 1'b0;
			outPort <= '0;
			outStrobe <= 1'b0;
		end else begin
			if (PCin)
				pc <= busOut;
			else if (incPC)
				pc <= pc + 32'd1;
			if (conIn)
				branchTaken <= condMet;
			if (OutPortin)
				outPort <= busOut;
			outStrobe <= OutPortin; // lines up with the new outPort value
		end
	end

	always_ff @(posedge clock) begin
		if (IRin) ir <= busOut;
		if (MARin) memAddress <= busOut[`MEM_ADDR_BITS-1:0];
		if (MDRin) mdr <= read ? memReadData : busOut; // memory on reads, bus on stores
		if (RYin) ryOut <= busOut;
		if (RZin) begin
			rzLo <= aluLo;
			rzHi <= aluHi;
		end
		if (RHIin) hi <= busOut;
		if (RLOin) lo <= busOut;
	end

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
	input logic clock,
	input logic reset,
	input cpuPkg::instructionT ir,
	input logic Gra, Grb, Grc, Rin, Rout, BAout, linkIn,
	input logic [31:0] busIn,
	output logic [31:0] rfData
);
	logic [31:0] regs [16];
	logic [3:0] sel;

	// field chosen by the select strobe
	always_comb begin
		sel = '0;
		if (Gra) sel = ir.regForm.ra;
		if (Grb) sel = ir.regForm.rb;
		if (Grc) sel = ir.regForm.rc;
	end

	always_comb begin
		rfData = '0;
		if (Rout)
			rfData = (BAout && sel == 4'd0) ? '0 : regs[sel]; // r0 as base means zero
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else begin
			if (Rin)
				regs[sel] <= busIn;
			if (linkIn)
				regs[15] <= busIn; // jal link
		end
	end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module alu (
	input logic clock,
	input logic reset,
	input cpuPkg::opcodeT aluOp,
	input logic aluStart,
	input logic [31:0] ryIn, busIn,
	output logic [31:0] aluLo, aluHi,
	output logic aluDone
);
	import cpuPkg::*;

	localparam int CountBits = $clog2(`MULDIV_CYCLES + 1);

	logic [CountBits-1:0] count;
	logic [31:0] heldHi, heldLo; // mul/div result until read out
	logic signed [63:0] product;
	logic [31:0] quotient, remainder;
	logic [31:0] mdHi, mdLo;
	logic [63:0] rorWide, rolWide;
	logic [4:0] shamt;
	logic isMulDiv;

	assign isMulDiv = (aluOp == opMul) || (aluOp == opDiv);
	assign shamt = busIn[4:0];
	assign rorWide = {ryIn, ryIn} >> shamt;
	assign rolWide = {ryIn, ryIn} << shamt;

	assign product = $signed(ryIn) * $signed(busIn);
	assign quotient = $signed(ryIn) / $signed(busIn);
	assign remainder = $signed(ryIn) % $signed(busIn);

	always_comb begin
		if (aluOp == opMul)
			{mdHi, mdLo} = product;
		else if (busIn == '0)
			{mdHi, mdLo} = {ryIn, 32'hffff_ffff}; // divide by zero
		else
			{mdHi, mdLo} = {remainder, quotient};
	end

	always_ff @(posedge clock) begin
		if (aluStart && isMulDiv) begin
			heldHi <= mdHi;
			heldLo <= mdLo;
		end
	end

	// fixed latency countdown, done on the last count
	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			count <= '0;
		else if (aluStart && isMulDiv)
			count <= CountBits'(`MULDIV_CYCLES);
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign aluDone = (count == CountBits'(1));

	always_comb begin
		aluHi = '0;
		aluLo = '0;
		case (aluOp)
			opAdd, opAddi: aluLo = ryIn + busIn; // also address and branch sums
			opSub: aluLo = ryIn - busIn;
			opShr: aluLo = ryIn >> shamt;
			opShl: aluLo = ryIn << shamt;
			opRor: aluLo = rorWide[31:0];
			opRol: aluLo = rolWide[63:32];
			opAnd, opAndi: aluLo = ryIn & busIn;
			opOr, opOri: aluLo = ryIn | busIn;
			opNeg: aluLo = -busIn;
			opNot: aluLo = ~busIn;
			opMul, opDiv: {aluHi, aluLo} = {heldHi, heldLo};
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module cpuTop (
	input logic clock,
	input logic reset,
	output logic [`MEM_ADDR_BITS-1:0] memAddress,
	output logic [31:0] memWriteData,
	input logic [31:0] memReadData,
	output logic read,
	output logic write,
	input logic [31:0] inPort,
	output logic [31:0] outPort,
	output logic outStrobe,
	output logic halted,
	output logic [15:0] instrCount
);
	import cpuPkg::*;

	instructionT ir;
	opcodeT aluOp;
	logic aluStart, aluDone, branchTaken;
	logic PCout, MDRout, Immout, InPortout, RZLOout, RZHIout, RHIout, RLOout, Rout;
	logic PCin, IRin, MARin, MDRin, RYin, RZin, RHIin, RLOin, OutPortin, conIn, incPC;
	logic Gra, Grb, Grc, Rin, BAout, linkIn;
	logic [31:0] busOut, ryOut, rfData, aluLo, aluHi;

	controlUnit control0 (.*);

	dataPath dataPath0 (.*);

	// both read the shared bus
	registerFile regFile0 (.*, .busIn(busOut));

	alu alu0 (.*, .ryIn(ryOut), .busIn(busOut));

endmodule

`default_nettype wire

// File: bench/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module cpuTb;
	import cpuPkg::*;

	localparam int ClockPeriod = 8;
	localparam int NumRows = 29;
	localparam int RowCycles = 368 + 4 * `MULDIV_CYCLES; // per program, mul/div waits included

	typedef enum logic [2:0] {
		kindAluReg, kindAluImm, kindMulDiv, kindBranch, kindStoreLoad, kindJalIo
	} kindT;

	typedef struct packed {
		kindT kind;
		opcodeT op;
		logic [31:0] a; // first operand, tested value or inPort
		logic [31:0] b; // second operand or branch condition
		logic [63:0] expected; // hi:lo for mul/div
	} rowT;

	logic clock, reset;
	logic [`MEM_ADDR_BITS-1:0] memAddress;
	logic [31:0] memWriteData, memReadData, inPort, outPort;
	logic read, write, outStrobe, halted;
	logic [15:0] instrCount;

	logic [31:0] mem [512];
	rowT rows [NumRows];
	int rowCount, rowIndex, progAddr, expCount, expWrites, writes;
	logic [31:0] expOut [$];
	logic [31:0] outs [$]; // values seen on outStrobe

	cpuTop dut0 (
		.clock(clock), .reset(reset),
		.memAddress(memAddress), .memWriteData(memWriteData), .memReadData(memReadData),
		.read(read), .write(write),
		.inPort(inPort), .outPort(outPort), .outStrobe(outStrobe),
		.halted(halted), .instrCount(instrCount)
	);

	assign memReadData = mem[memAddress]; // combinational read

	always #(ClockPeriod / 2) clock = ~clock;

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got %h, expected %h (row %0d)", name, got, expected, rowIndex);
			$display("SOME TESTS FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// expected results straight from the instruction rules
	function automatic logic [63:0] referenceResult(kindT kind, opcodeT op,
			logic [31:0] a, logic [31:0] b);
		logic signed [31:0] sa, sb;
		logic signed [63:0] wideA, wideB;
		logic [4:0] s;
		logic [63:0] r;
		logic taken;
		sa = a;
		sb = b;
		wideA = sa;
		wideB = sb;
		s = b[4:0]; // shifts only look at 5 bits
		r = '0;
		taken = 1'b0;
		case (kind)
			kindBranch: begin
				case (b[1:0])
					2'd0: taken = (a == 32'd0);
					2'd1: taken = (a != 32'd0);
					2'd2: taken = (sa > 0); // zero is not positive
					default: taken = (sa < 0);
				endcase
				r = taken ? 64'd1 : 64'd2; // which out runs
			end
			kindStoreLoad, kindJalIo: r = {32'd0, a}; // value comes back unchanged
			default: begin
				case (op)
					opAdd, opAddi: r[31:0] = a + b;
					opSub: r[31:0] = a - b;
					opShr: r[31:0] = a >> s;
					opShl: r[31:0] = a << s;
					opRor: r[31:0] = (a >> s) | (a << (6'd32 - s));
					opRol: r[31:0] = (a << s) | (a >> (6'd32 - s));
					opAnd, opAndi: r[31:0] = a & b;
					opOr, opOri: r[31:0] = a | b;
					opNeg: r[31:0] = 32'd0 - a;
					opNot: r[31:0] = ~a;
					opMul: r = wideA * wideB;
					opDiv: begin
						if (b == 32'd0)
							r = {a, 32'hffff_ffff}; // divide by zero rule
						else
							r = {32'(sa % sb), 32'(sa / sb)};
					end
					default: r = '0;
				endcase
			end
		endcase
		return r;
	endfunction

	task automatic addRow(kindT kind, opcodeT op, logic [31:0] a, logic [31:0] b);
		rowT r;
		r.kind = kind;
		r.op = op;
		r.a = a;
		r.b = b;
		r.expected = referenceResult(kind, op, a, b);
		rows[rowCount] = r;
		rowCount++;
	endtask

	function automatic logic [31:0] signExt19(logic [31:0] x);
		return {{13{x[18]}}, x[18:0]}; // fits the immediate field
	endfunction

	task automatic fillTable();
		opcodeT regOps [10] = '{opAdd, opSub, opShr, opShl, opRor, opRol, opAnd, opOr,
			opNeg, opNot};
		opcodeT immOps [3] = '{opAddi, opAndi, opOri};
		foreach (regOps[i])
			addRow(kindAluReg, regOps[i], $urandom(), $urandom());
		foreach (immOps[i])
			addRow(kindAluImm, immOps[i], $urandom(), signExt19($urandom()));
		addRow(kindMulDiv, opMul, $urandom(), $urandom());
		addRow(kindMulDiv, opMul, -32'sd7, 32'd123456); // negative product
		addRow(kindMulDiv, opDiv, $urandom(), $urandom());
		addRow(kindMulDiv, opDiv, -32'sd100, 32'd7);
		addRow(kindMulDiv, opDiv, 32'd55, 32'd0);
		addRow(kindBranch, opBr, 32'd0, 32'd0); // zero, taken
		addRow(kindBranch, opBr, 32'd5, 32'd0);
		addRow(kindBranch, opBr, 32'd9, 32'd1); // nonzero
		addRow(kindBranch, opBr, 32'd0, 32'd1);
		addRow(kindBranch, opBr, 32'd7, 32'd2); // positive
		addRow(kindBranch, opBr, 32'd0, 32'd2);
		addRow(kindBranch, opBr, -32'sd3, 32'd3); // negative
		addRow(kindBranch, opBr, 32'd4, 32'd3);
		addRow(kindStoreLoad, opSt, $urandom(), 32'd0);
		addRow(kindStoreLoad, opSt, $urandom(), 32'd0);
		addRow(kindJalIo, opJal, $urandom(), 32'd0);
	endtask

	function automatic instructionT regWord(opcodeT op, int ra, int rb, int rc);
		instructionT w;
		w.regForm.opcode = op;
		w.regForm.ra = 4'(ra);
		w.regForm.rb = 4'(rb);
		w.regForm.rc = 4'(rc);
		w.regForm.spare = '0;
		return w;
	endfunction

	function automatic instructionT immWord(opcodeT op, int ra, int rb, int k);
		instructionT w;
		w.immForm.opcode = op;
		w.immForm.ra = 4'(ra);
		w.immForm.rb = 4'(rb);
		w.immForm.constant = 19'(k);
		return w;
	endfunction

	task automatic emit(instructionT w);
		mem[progAddr] = w;
		progAddr++;
	endtask

	// program and data words for one row, plus what it should produce
	task automatic loadProgram(rowT row);
		for (int i = 0; i < 512; i++)
			mem[i] = 32'hc0de_0000 + 32'(i);
		mem[256] = row.a;
		mem[257] = row.b;
		progAddr = `RESET_PC;
		expOut.delete();
		expWrites = 0;
		case (row.kind)
			kindAluReg, kindAluImm: begin
				emit(immWord(opLd, 1, 0, 256));
				if (row.kind == kindAluReg) begin
					emit(immWord(opLd, 2, 0, 257));
					emit(regWord(row.op, 3, 1, 2)); // neg/not ignore rc
				end else
					emit(immWord(row.op, 3, 1, int'(row.b)));
				emit(regWord(opOut, 3, 0, 0));
				expOut.push_back(row.expected[31:0]);
				expCount = (row.kind == kindAluReg) ? 5 : 4;
			end
			kindMulDiv: begin
				emit(immWord(opLd, 1, 0, 256));
				emit(immWord(opLd, 2, 0, 257));
				emit(regWord(row.op, 1, 2, 0));
				emit(regWord(opMfhi, 3, 0, 0));
				emit(regWord(opMflo, 4, 0, 0));
				emit(regWord(opOut, 3, 0, 0));
				emit(regWord(opOut, 4, 0, 0));
				expOut.push_back(row.expected[63:32]);
				expOut.push_back(row.expected[31:0]);
				expCount = 8;
			end
			kindBranch: begin
				emit(immWord(opLd, 1, 0, 256));
				emit(immWord(opLdi, 5, 0, 1));
				emit(immWord(opLdi, 6, 0, 2));
				emit(immWord(opBr, 1, int'(row.b[1:0]), 2)); // skips two words
				emit(regWord(opOut, 6, 0, 0)); // fall through
				emit(regWord(opHalt, 0, 0, 0));
				emit(regWord(opOut, 5, 0, 0)); // target
				expOut.push_back(row.expected[31:0]);
				expCount = 6;
			end
			kindStoreLoad: begin
				emit(immWord(opLd, 1, 0, 256));
				emit(immWord(opLdi, 0, 0, 7)); // r0 holds 7, base still zero
				emit(immWord(opSt, 1, 0, 304));
				emit(immWord(opLdi, 2, 0, 300));
				emit(immWord(opLd, 4, 2, 4)); // same word through r2
				emit(regWord(opOut, 4, 0, 0));
				expOut.push_back(row.expected[31:0]);
				expCount = 7;
				expWrites = 1;
			end
			default: begin
				emit(immWord(opLdi, 7, 0, int'(`RESET_PC) + 5));
				emit(regWord(opJal, 7, 0, 0));
				emit(regWord(opIn, 3, 0, 0)); // return lands here
				emit(regWord(opOut, 3, 0, 0));
				emit(regWord(opHalt, 0, 0, 0));
				emit(regWord(opOut, 15, 0, 0)); // routine
				emit(regWord(opJr, 15, 0, 0));
				expOut.push_back(`RESET_PC + 32'd2);
				expOut.push_back(row.expected[31:0]);
				expCount = 7;
			end
		endcase
		if (row.kind != kindJalIo)
			emit(regWord(opHalt, 0, 0, 0));
	endtask

	initial begin
		#(NumRows * RowCycles * ClockPeriod);
		$display("timeout: a program never reached halt");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		inPort = '0;
		void'($urandom(32'h8ae36c8d));
		rowCount = 0;
		rowIndex = 0;
		fillTable();
		for (rowIndex = 0; rowIndex < NumRows; rowIndex++) begin
			@(posedge clock);
			reset <= 1'b1;
			loadProgram(rows[rowIndex]);
			repeat (8) @(posedge clock);
			checkValue("write", 32'(write), 32'd0); // quiet while in reset
			checkValue("read", 32'(read), 32'd0);
			checkValue("outStrobe", 32'(outStrobe), 32'd0);
			checkValue("halted", 32'(halted), 32'd0);
			checkValue("instrCount", 32'(instrCount), 32'd0);
			reset <= 1'b0;
			inPort <= rows[rowIndex].a;
			outs.delete();
			writes = 0;
			do begin
				@(posedge clock);
				if (outStrobe)
					outs.push_back(outPort);
				if (write) begin
					mem[memAddress] <= memWriteData;
					writes++;
				end
			end while (!halted);
			checkValue("instrCount", 32'(instrCount), expCount);
			checkValue("writeCount", writes, expWrites); // no stray writes
			checkValue("outCount", outs.size(), expOut.size()); // no stray strobes
			foreach (outs[i])
				checkValue("outPort", outs[i], expOut[i]);
			if (rows[rowIndex].kind == kindStoreLoad)
				checkValue("mem[304]", mem[304], rows[rowIndex].a);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/controlUnit.sv
rtl/dataPath.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/cpuTop.sv
bench/cpuTb.sv

// File: Makefile
SOURCES := vlog.f $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/VcpuTb: $(SOURCES)
	verilator --binary --timing -f vlog.f --top-module cpuTb

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
